// ==== src.f ====
verilog/box_pkg.sv
verilog/column_adder_tree.sv
verilog/window_accumulator.sv
verilog/center_pixel_delay.sv
verilog/threshold_decision.sv
verilog/local_mean_binarizer.sv
tb/tb_clock_gen.sv
tb/result_checker.sv
tb/local_mean_binarizer_assert.sv
tb/local_mean_binarizer_tb.sv

// ==== tb/local_mean_binarizer_tb.sv ====
`default_nettype none

module local_mean_binarizer_tb
    import box_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [1:0] {PAT_CONST, PAT_RAMP, PAT_MAX, PAT_RANDOM} pattern_e;

    typedef struct packed {
        int       n_cols;
        pattern_e kind;
        int       value;  // Level, or ramp step per column.
        pixel_t   bias;
        int       gap;    // Most idle cycles after a strobe.
    } line_entry_t;

    logic        clk;
    logic        rst;
    column_t     i_column;
    pixel_t      i_bias;
    result_t     o_result;
    line_entry_t lines [$];
    int          seed;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;
    int          value_errors;
    int          protocol_errors;
    int          count_errors;
    int          assert_errors;
    int          checked;
    int          pending;

    tb_clock_gen clock_gen_inst (.clk(clk));

    local_mean_binarizer local_mean_binarizer_inst (
        .clk      (clk),
        .rst      (rst),
        .i_column (i_column),
        .i_bias   (i_bias),
        .o_result (o_result)
    );

    result_checker result_checker_inst (
        .clk               (clk),
        .rst               (rst),
        .i_column          (i_column),
        .i_bias            (i_bias),
        .i_result          (o_result),
        .o_value_errors    (value_errors),
        .o_protocol_errors (protocol_errors),
        .o_checked         (checked),
        .o_pending         (pending)
    );

    task automatic add_line(input int n, input pattern_e kind, input int value,
                            input int bias, input int gap);
        line_entry_t e;
        e.n_cols = n;
        e.kind   = kind;
        e.value  = value;
        e.bias   = pixel_t'(bias);
        e.gap    = gap;
        lines.push_back(e);
    endtask

    function automatic pixel_t pixel_for(line_entry_t e, int col);
        case (e.kind)
            PAT_CONST: return pixel_t'(e.value);
            PAT_RAMP:  return pixel_t'(col * e.value);  // Wraps at 256.
            PAT_MAX:   return 8'hff;
            default:   return pixel_t'($random(seed));
        endcase
    endfunction

    task automatic drive_column(input line_entry_t e, input int col);
        column_t c;
        c.valid      = 1'b1;
        c.line_start = (col == 0);
        for (int r = 0; r < WIN; r++) begin
            c.pixels[r] = pixel_for(e, col);
        end
        @(negedge clk);
        i_column = c;
        i_bias   = e.bias;
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        i_column.valid      = 1'b0;
        i_column.line_start = 1'b0;
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, the stimulus did not finish", cycle_cnt);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        int total_cols;
        int max_gap;
        int exp_results;
        int gaps;
        seed         = 32'h5f6db017;
        rst          = 1'b1;
        i_column     = '0;
        i_bias       = '0;
        count_errors = 0;

        add_line(20, PAT_CONST, 100, 0, 0);
        add_line(30, PAT_RANDOM, 0, 10, 0);
        add_line(12, PAT_RANDOM, 0, 5, 2);  // One short of a window.
        add_line(26, PAT_RAMP, 9, 0, 0);
        add_line(26, PAT_RAMP, 23, 255, 0);
        add_line(24, PAT_RAMP, 5, 40, 3);
        add_line(30, PAT_RANDOM, 0, 128, 4);
        add_line(20, PAT_MAX, 0, 0, 1);
        add_line(16, PAT_CONST, 50, 3, 0);

        total_cols  = 0;
        max_gap     = 0;
        exp_results = 0;
        foreach (lines[i]) begin
            total_cols += lines[i].n_cols;
            if (lines[i].gap > max_gap) begin
                max_gap = lines[i].gap;
            end
            if (lines[i].n_cols >= WIN) begin
                exp_results += lines[i].n_cols - WIN + 1;
            end
        end
        cycle_limit = total_cols * (max_gap + 1) + 50;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        foreach (lines[i]) begin
            for (int c = 0; c < lines[i].n_cols; c++) begin
                drive_column(lines[i], c);
                gaps = $unsigned($random(seed)) % (lines[i].gap + 1);
                repeat (gaps) idle_cycle();
            end
        end
        idle_cycle();
        while (pending != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);  // Catch stray pulses.

        if (checked != exp_results) begin
            $display("Checked %0d results but the table holds %0d full windows",
                     checked, exp_results);
            count_errors++;
        end
        assert_errors = local_mean_binarizer_inst.local_mean_binarizer_assert_inst.fail_count;
        $display("Errors: %0d value, %0d protocol, %0d count, %0d assertion (%0d checked)",
                 value_errors, protocol_errors, count_errors, assert_errors, checked);
        if (value_errors + protocol_errors + count_errors + assert_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/local_mean_binarizer_assert.sv ====
`default_nettype none

module local_mean_binarizer_assert
    import box_pkg::*;
(
    input wire          clk,
    input wire          rst,
    input wire column_t i_column,
    input wire result_t i_result
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    reset_quiet: assert property (@(posedge clk) rst |=> !i_result.valid)
        else begin
            $error("o_result.valid high during reset");
            fail_count++;
        end

    // Tree 4, accumulator 1, decision 1.
    fixed_latency: assert property (@(posedge clk) disable iff (rst)
        i_result.valid |-> $past(i_column.valid, 6))
        else begin
            $error("o_result.valid without a strobe 6 cycles earlier");
            fail_count++;
        end

    sum_in_range: assert property (@(posedge clk) disable iff (rst)
        i_result.valid |-> (i_result.win_sum <= win_sum_t'(AREA * 255)))
        else begin
            $error("o_result.win_sum above the largest window sum");
            fail_count++;
        end

endmodule

bind local_mean_binarizer local_mean_binarizer_assert local_mean_binarizer_assert_inst (
    .clk      (clk),
    .rst      (rst),
    .i_column (i_column),
    .i_result (o_result)
);

`default_nettype wire

// ==== tb/result_checker.sv ====
`default_nettype none

module result_checker
    import box_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  wire column_t i_column,
    input  wire pixel_t  i_bias,
    input  wire result_t i_result,
    output int           o_value_errors,
    output int           o_protocol_errors,
    output int           o_checked,
    output int           o_pending
);
    timeunit 1ns;
    timeprecision 1ps;

    int     col_sums [$];  // Current line, newest last.
    pixel_t centers [$];
    int     exp_sum [$];
    pixel_t exp_center [$];
    int     due [$];
    int     cycle;
    pixel_t prev_bias;  // What the decision stage saw.

    function automatic int column_total(column_t c);
        int total;
        total = 0;
        for (int r = 0; r < WIN; r++) begin
            total += int'(c.pixels[r]);
        end
        return total;
    endfunction

    task automatic compare(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
            o_value_errors++;
        end
    endtask

    always @(posedge clk) begin
        int win;
        int exp_bin;
        if (rst) begin
            cycle             = 0;
            o_value_errors    = 0;
            o_protocol_errors = 0;
            o_checked         = 0;
            col_sums.delete();
            centers.delete();
            exp_sum.delete();
            exp_center.delete();
            due.delete();
        end else begin
            cycle++;
            if (due.size() > 0 && due[0] == cycle) begin
                if (!i_result.valid) begin
                    $display("%0t: a result was due but o_result.valid stayed low", $time);
                    o_protocol_errors++;
                end else begin
                    exp_bin = (AREA * (int'(exp_center[0]) + int'(prev_bias)) >= exp_sum[0]);
                    compare("o_result.win_sum", i_result.win_sum, exp_sum[0]);
                    compare("o_result.center", i_result.center, exp_center[0]);
                    compare("o_result.bin", i_result.bin, exp_bin);
                    o_checked++;
                end
                void'(due.pop_front());
                void'(exp_sum.pop_front());
                void'(exp_center.pop_front());
            end else if (i_result.valid) begin
                $display("%0t: o_result.valid pulsed with no result due", $time);
                o_protocol_errors++;
            end

            if (i_column.valid) begin
                if (i_column.line_start) begin
                    col_sums.delete();  // New line, old columns drop out.
                    centers.delete();
                end
                col_sums.push_back(column_total(i_column));
                centers.push_back(i_column.pixels[CENTER_ROW]);
                if (col_sums.size() > WIN) begin
                    void'(col_sums.pop_front());
                    void'(centers.pop_front());
                end
                if (col_sums.size() == WIN) begin
                    win = 0;
                    foreach (col_sums[i]) begin
                        win += col_sums[i];
                    end
                    exp_sum.push_back(win);
                    exp_center.push_back(centers[WIN-1-CENTER_LAG]);
                    due.push_back(cycle + 6);
                end
            end
            prev_bias = i_bias;
        end
        o_pending = due.size();
    end

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== verilog/local_mean_binarizer.sv ====
`default_nettype none

module local_mean_binarizer
    import box_pkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire column_t  i_column,
    input  wire pixel_t   i_bias,
    output result_t       o_result
);

    wire col_sum_word_t col_sum;
    wire                win_valid;
    wire win_sum_t      win_sum;
    wire pixel_t        center;

    // Sum path.
    column_adder_tree column_adder_tree_inst (
        .clk       (clk),
        .rst       (rst),
        .i_column  (i_column),
        .o_col_sum (col_sum)
    );

    window_accumulator window_accumulator_inst (
        .clk         (clk),
        .rst         (rst),
        .i_col_sum   (col_sum),
        .o_win_valid (win_valid),
        .o_win_sum   (win_sum)
    );

    // Center path, runs beside the sum path.
    center_pixel_delay center_pixel_delay_inst (
        .clk      (clk),
        .rst      (rst),
        .i_column (i_column),
        .o_center (center)
    );

    threshold_decision threshold_decision_inst (
        .clk         (clk),
        .rst         (rst),
        .i_win_valid (win_valid),
        .i_win_sum   (win_sum),
        .i_center    (center),
        .i_bias      (i_bias),
        .o_result    (o_result)
    );

endmodule

`default_nettype wire

// ==== verilog/threshold_decision.sv ====
`default_nettype none

module threshold_decision
    import box_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire            i_win_valid,
    input  wire win_sum_t  i_win_sum,
    input  wire pixel_t    i_center,
    input  wire pixel_t    i_bias,
    output result_t        o_result
);

    logic [8:0]  biased;
    logic [16:0] scaled;  // 510 x 169 fits in 17 bits.
    logic        bin;
    result_t     res;

    assign biased = 9'(i_center) + 9'(i_bias);
    assign scaled = 17'(biased) * 17'(AREA);
    assign bin    = (scaled >= 17'(i_win_sum));

    always_ff @(posedge clk) begin
        if (rst) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= i_win_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_win_valid) begin
            res.bin     <= bin;
            res.win_sum <= i_win_sum;
            res.center  <= i_center;
        end
    end

    assign o_result = res;

endmodule

`default_nettype wire

// ==== verilog/center_pixel_delay.sv ====
`default_nettype none

module center_pixel_delay
    import box_pkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire column_t  i_column,
    output pixel_t        o_center
);

    // Center row of the previous columns, one back at index 0.
    pixel_t hist [CENTER_LAG];

    // Matches tree plus accumulator latency.
    pixel_t dly [TREE_LATENCY+1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < CENTER_LAG; i++) begin
                hist[i] <= '0;
            end
        end else if (i_column.valid) begin
            hist[0] <= i_column.pixels[CENTER_ROW];
            for (int i = 1; i < CENTER_LAG; i++) begin
                hist[i] <= hist[i-1];
            end
        end
    end

    // Free running, so gaps between strobes keep alignment.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i <= TREE_LATENCY; i++) begin
                dly[i] <= '0;
            end
        end else begin
            dly[0] <= hist[CENTER_LAG-1];  // Sampled on the strobe cycle.
            for (int i = 1; i <= TREE_LATENCY; i++) begin
                dly[i] <= dly[i-1];
            end
        end
    end

    assign o_center = dly[TREE_LATENCY];

endmodule

`default_nettype wire

// ==== verilog/window_accumulator.sv ====
`default_nettype none

module window_accumulator
    import box_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst,
    input  wire col_sum_word_t  i_col_sum,
    output logic                o_win_valid,
    output win_sum_t            o_win_sum
);

    col_sum_t   hist [WIN];  // Last 13 column sums, newest at 0.
    win_state_e state;
    logic [3:0] fill_cnt;
    win_sum_t   win_sum;
    logic       win_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= WIN_EMPTY;
            fill_cnt  <= '0;
            win_sum   <= '0;
            win_valid <= 1'b0;
            for (int i = 0; i < WIN; i++) begin
                hist[i] <= '0;
            end
        end else begin
            win_valid <= 1'b0;
            if (i_col_sum.valid) begin
                hist[0] <= i_col_sum.sum;
                for (int i = 1; i < WIN; i++) begin
                    hist[i] <= hist[i-1];
                end

                if (i_col_sum.line_start || state == WIN_EMPTY) begin
                    // Fresh window, older history is ignored.
                    win_sum  <= win_sum_t'(i_col_sum.sum);
                    fill_cnt <= 4'd1;
                    state    <= WIN_FILLING;
                end else if (state == WIN_FILLING) begin
                    win_sum  <= win_sum + win_sum_t'(i_col_sum.sum);
                    fill_cnt <= fill_cnt + 4'd1;
                    if (fill_cnt == 4'(WIN - 1)) begin
                        state     <= WIN_FULL;
                        win_valid <= 1'b1;  // Window just completed.
                    end
                end else begin
                    win_sum   <= win_sum + win_sum_t'(i_col_sum.sum)
                                 - win_sum_t'(hist[WIN-1]);
                    win_valid <= 1'b1;
                end
            end
        end
    end

    assign o_win_valid = win_valid;
    assign o_win_sum   = win_sum;

endmodule

`default_nettype wire

// ==== verilog/column_adder_tree.sv ====
`default_nettype none

module column_adder_tree
    import box_pkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire column_t  i_column,
    output col_sum_word_t o_col_sum
);

    logic [8:0]  s1 [7];  // 13 -> 7.
    logic [9:0]  s2 [4];  // 7 -> 4.
    logic [10:0] s3 [2];  // 4 -> 2.
    logic [11:0] s4;      // 2 -> 1.

    logic [TREE_LATENCY-1:0] vld_pipe;
    logic [TREE_LATENCY-1:0] ls_pipe;

    always_ff @(posedge clk) begin
        for (int i = 0; i < 6; i++) begin
            s1[i] <= 9'(i_column.pixels[2*i]) + 9'(i_column.pixels[2*i+1]);
        end
        s1[6] <= 9'(i_column.pixels[WIN-1]);  // Odd pixel rides along.
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 3; i++) begin
            s2[i] <= 10'(s1[2*i]) + 10'(s1[2*i+1]);
        end
        s2[3] <= 10'(s1[6]);
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            s3[i] <= 11'(s2[2*i]) + 11'(s2[2*i+1]);
        end
    end

    always_ff @(posedge clk) begin
        s4 <= 12'(s3[0]) + 12'(s3[1]);
    end

    // Strobe and line start follow the partial sums.
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[TREE_LATENCY-2:0], i_column.valid};
        end
    end

    always_ff @(posedge clk) begin
        ls_pipe <= {ls_pipe[TREE_LATENCY-2:0], i_column.line_start};
    end

    assign o_col_sum = '{
        valid:      vld_pipe[TREE_LATENCY-1],
        line_start: ls_pipe[TREE_LATENCY-1],
        sum:        s4
    };

endmodule

`default_nettype wire

// ==== verilog/box_pkg.sv ====
`default_nettype none

package box_pkg;

    localparam int WIN          = 13;
    localparam int CENTER_ROW   = 6;
    localparam int CENTER_LAG   = 6;  // Columns between newest and center.
    localparam int AREA         = WIN * WIN;
    localparam int TREE_LATENCY = 4;

    typedef logic [7:0]  pixel_t;
    typedef logic [11:0] col_sum_t;  // 13 x 255 = 3315.
    typedef logic [15:0] win_sum_t;  // 169 x 255 = 43095.

    // One input column, pixel 0 at the top.
    typedef struct packed {
        logic                 valid;
        logic                 line_start;
        pixel_t [WIN-1:0]     pixels;
    } column_t;

    typedef struct packed {
        logic     valid;
        logic     line_start;
        col_sum_t sum;
    } col_sum_word_t;

    typedef struct packed {
        logic     valid;
        logic     bin;
        win_sum_t win_sum;
        pixel_t   center;
    } result_t;

    typedef enum logic [1:0] {
        WIN_EMPTY,
        WIN_FILLING,
        WIN_FULL
    } win_state_e;

endpackage

`default_nettype wire
